/* hw/periph_pkg.sv */
// ------------------------------------------------------------------
// Peripheral subsystem shared definitions
// Widths, register map, RNG constants and the bus FSM states
// ------------------------------------------------------------------
package periph_pkg;

    // Bus and register widths
    typedef logic [7:0]  addr_t;     // AXI4-Lite byte address
    typedef logic [31:0] data_t;     // Register data word
    typedef logic [3:0]  reg_idx_t;  // Word index, address bits 5..2
    typedef logic [1:0]  resp_t;     // AXI response code
    typedef logic [7:0]  led_t;      // LED and DIP value
    typedef logic [1:0]  irq_vec_t;  // Bit 0 RNG full, bit 1 DIP change
    typedef logic [3:0]  cnt_t;      // FIFO fill count

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_SLVERR = 2'd2;

    // ------------------------------------------------------------------
    // Random number source
    // ------------------------------------------------------------------
    localparam int    RNG_DEPTH = 8;
    localparam data_t RNG_SEED  = 32'h0000_0001;  // First word pushed
    localparam data_t RNG_TAPS  = 32'h8020_0003;  // Bits 31, 21, 1, 0

    // Returned for any index outside the map
    localparam data_t BAD_DATA = 32'hDEAD_BEEF;

    // ------------------------------------------------------------------
    // Register map, word indices
    // ------------------------------------------------------------------
    localparam reg_idx_t REG_LEDS     = 4'd0;  // 0x00 rw
    localparam reg_idx_t REG_DIP      = 4'd1;  // 0x04 ro
    localparam reg_idx_t REG_RNG_DATA = 4'd2;  // 0x08 read pops
    localparam reg_idx_t REG_RNG_STAT = 4'd3;  // 0x0C ro
    localparam reg_idx_t REG_IRQ_PEND = 4'd4;  // 0x10 w1c
    localparam reg_idx_t REG_IRQ_EN   = 4'd5;  // 0x14 rw

    // Bus FSM
    typedef enum logic [1:0] {
        IDLE,
        WRITE_RESP,
        READ_RESP
    } ctrl_state_e;

endpackage

/* hw/gpio_regs.sv */
`timescale 1ns/1ps
// ------------------------------------------------------------------
// GPIO registers
// Writable LED register, two-stage DIP synchronizer and a
// change detector that flags any new DIP value
// ------------------------------------------------------------------
module gpio_regs
    import periph_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  led_we_i,
    input  data_t wdata_i,
    input  led_t  dip_switches_i,
    output led_t  leds_o,
    output led_t  dip_q_o,
    output logic  dip_changed_o
);

    led_t leds_q;
    led_t dip_meta_q;  // First synchronizer stage
    led_t dip_sync_q;
    led_t dip_prev_q;
    logic changed_q;

    // LED register takes the low byte
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            leds_q <= '0;
        else if (led_we_i)
            leds_q <= wdata_i[7:0];
    end

    // ------------------------------------------------------------------
    // DIP input path
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            dip_meta_q <= '0;
            dip_sync_q <= '0;
            dip_prev_q <= '0;
            changed_q  <= 1'b0;
        end
        else
        begin
            dip_meta_q <= dip_switches_i;
            dip_sync_q <= dip_meta_q;
            dip_prev_q <= dip_sync_q;
            changed_q  <= (dip_sync_q != dip_prev_q);  // Single-cycle pulse
        end
    end

    assign leds_o        = leds_q;
    assign dip_q_o       = dip_sync_q;
    assign dip_changed_o = changed_q;

endmodule

/* hw/rng_fifo.sv */
`timescale 1ns/1ps
// ------------------------------------------------------------------
// Random number source
// 32-bit Fibonacci LFSR that keeps a small circular FIFO topped up,
// one word per cycle while there is room
// ------------------------------------------------------------------
module rng_fifo
    import periph_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  pop_i,
    output data_t data_o,
    output cnt_t  count_o,
    output logic  full_o,
    output logic  empty_o
);

    data_t                          mem_q [RNG_DEPTH];
    logic [$clog2(RNG_DEPTH)-1:0]   wr_ptr_q, rd_ptr_q;
    cnt_t                           count_q;
    data_t                          lfsr_q, lfsr_next;
    logic                           feedback;
    logic                           push, pop;
    logic                           full, empty;

    assign full  = (count_q == cnt_t'(RNG_DEPTH));
    assign empty = (count_q == '0);

    assign push = !full;
    assign pop  = pop_i && !empty;  // Pop on empty is dropped

    // ------------------------------------------------------------------
    // LFSR, shift left with XOR of tapped bits into bit 0
    // ------------------------------------------------------------------
    assign feedback  = ^(lfsr_q & RNG_TAPS);
    assign lfsr_next = {lfsr_q[30:0], feedback};

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            lfsr_q   <= RNG_SEED;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (push)
            begin
                lfsr_q   <= lfsr_next;  // Step only when a word is pushed
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop)
                rd_ptr_q <= rd_ptr_q + 1'b1;

            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // Both or neither
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk_i)
    begin
        if (push)
            mem_q[wr_ptr_q] <= lfsr_q;
    end

    assign data_o  = mem_q[rd_ptr_q];  // Head word, stale when empty
    assign count_o = count_q;
    assign full_o  = full;
    assign empty_o = empty;

endmodule

/* hw/irq_unit.sv */
`timescale 1ns/1ps
// ------------------------------------------------------------------
// Interrupt unit
// Pending and enable registers for two sources, one interrupt line
// ------------------------------------------------------------------
module irq_unit
    import periph_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     en_we_i,
    input  logic     clr_we_i,
    input  data_t    wdata_i,
    input  logic     rng_full_i,
    input  logic     dip_changed_i,
    output irq_vec_t pend_o,
    output irq_vec_t en_o,
    output logic     irq_o
);

    irq_vec_t en_q;
    irq_vec_t pend;
    logic     dip_pend_q;
    logic     irq_q;

    // Bit 0 is a level source, bit 1 is latched
    assign pend = {dip_pend_q, rng_full_i};

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            en_q       <= '0;
            dip_pend_q <= 1'b0;
            irq_q      <= 1'b0;
        end
        else
        begin
            if (en_we_i)
                en_q <= wdata_i[1:0];
            if (dip_changed_i)
                dip_pend_q <= 1'b1;  // New change beats a clear
            else if (clr_we_i && wdata_i[1])
                dip_pend_q <= 1'b0;
            irq_q <= |(pend & en_q);
        end
    end

    assign pend_o = pend;
    assign en_o   = en_q;
    assign irq_o  = irq_q;

endmodule

/* hw/periph_ctrl.sv */
`timescale 1ns/1ps
// ------------------------------------------------------------------
// AXI4-Lite slave control for the peripheral block
// One transaction at a time, word index decode into register strobes,
// registered read data and response codes
// ------------------------------------------------------------------
module periph_ctrl
    import periph_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    // AXI4-Lite slave
    input  addr_t      s_awaddr_i,
    input  logic       s_awvalid_i,
    output logic       s_awready_o,
    input  data_t      s_wdata_i,
    input  logic [3:0] s_wstrb_i,   // Whole-word writes only
    input  logic       s_wvalid_i,
    output logic       s_wready_o,
    output resp_t      s_bresp_o,
    output logic       s_bvalid_o,
    input  logic       s_bready_i,
    input  addr_t      s_araddr_i,
    input  logic       s_arvalid_i,
    output logic       s_arready_o,
    output data_t      s_rdata_o,
    output resp_t      s_rresp_o,
    output logic       s_rvalid_o,
    input  logic       s_rready_i,
    // Register strobes
    output logic       led_we_o,
    output logic       irq_en_we_o,
    output logic       irq_clr_we_o,
    output logic       rng_pop_o,
    output data_t      wdata_o,
    // Read values
    input  led_t       led_q_i,
    input  led_t       dip_q_i,
    input  data_t      rng_data_i,
    input  cnt_t       rng_count_i,
    input  logic       rng_full_i,
    input  logic       rng_empty_i,
    input  irq_vec_t   irq_pend_i,
    input  irq_vec_t   irq_en_i
);

    ctrl_state_e state_q, state_d;
    reg_idx_t    rd_idx, wr_idx;
    logic        rd_accept, wr_accept;
    data_t       rdata_d, rdata_q;
    resp_t       rresp_d, rresp_q;
    resp_t       bresp_d, bresp_q;

    assign rd_idx = s_araddr_i[5:2];
    assign wr_idx = s_awaddr_i[5:2];

    // Reads take priority over a write arriving in the same cycle
    assign rd_accept = (state_q == IDLE) && s_arvalid_i;
    assign wr_accept = (state_q == IDLE) && !s_arvalid_i && s_awvalid_i && s_wvalid_i;

    assign s_arready_o = rd_accept;
    assign s_awready_o = wr_accept;
    assign s_wready_o  = wr_accept;

    // ------------------------------------------------------------------
    // Strobes, one cycle each
    // ------------------------------------------------------------------
    assign led_we_o     = wr_accept && (wr_idx == REG_LEDS);
    assign irq_en_we_o  = wr_accept && (wr_idx == REG_IRQ_EN);
    assign irq_clr_we_o = wr_accept && (wr_idx == REG_IRQ_PEND);
    assign rng_pop_o    = rd_accept && (rd_idx == REG_RNG_DATA);
    assign wdata_o      = s_wdata_i;

    // Read word, sampled on the accept edge
    always_comb
    begin
        rresp_d = RESP_OKAY;
        case (rd_idx)
            REG_LEDS:     rdata_d = {24'b0, led_q_i};
            REG_DIP:      rdata_d = {24'b0, dip_q_i};
            REG_RNG_DATA: rdata_d = rng_data_i;  // Head word, before the pop
            REG_RNG_STAT: rdata_d = {rng_full_i, rng_empty_i, 26'b0, rng_count_i};
            REG_IRQ_PEND: rdata_d = {30'b0, irq_pend_i};
            REG_IRQ_EN:   rdata_d = {30'b0, irq_en_i};
            default:
            begin
                rdata_d = BAD_DATA;
                rresp_d = RESP_SLVERR;
            end
        endcase
    end

    // Writes to read-only registers are dropped but still OKAY
    always_comb
    begin
        case (wr_idx)
            REG_LEDS, REG_DIP, REG_RNG_DATA,
            REG_RNG_STAT, REG_IRQ_PEND, REG_IRQ_EN: bresp_d = RESP_OKAY;
            default:                                bresp_d = RESP_SLVERR;
        endcase
    end

    // ------------------------------------------------------------------
    // Transaction FSM
    // ------------------------------------------------------------------
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            IDLE:
            begin
                if (rd_accept)
                    state_d = READ_RESP;
                else if (wr_accept)
                    state_d = WRITE_RESP;
            end
            WRITE_RESP:
            begin
                if (s_bready_i)
                    state_d = IDLE;
            end
            READ_RESP:
            begin
                if (s_rready_i)
                    state_d = IDLE;
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            state_q <= IDLE;
        else
            state_q <= state_d;
    end

    // Response payload holds until the master takes it
    always_ff @(posedge clk_i)
    begin
        if (rd_accept)
        begin
            rdata_q <= rdata_d;
            rresp_q <= rresp_d;
        end
        if (wr_accept)
            bresp_q <= bresp_d;
    end

    assign s_rvalid_o = (state_q == READ_RESP);
    assign s_rdata_o  = rdata_q;
    assign s_rresp_o  = rresp_q;
    assign s_bvalid_o = (state_q == WRITE_RESP);
    assign s_bresp_o  = bresp_q;

endmodule

/* hw/periph_top.sv */
`timescale 1ns/1ps
// ------------------------------------------------------------------
// Peripheral subsystem top level
// AXI4-Lite control plus GPIO, RNG FIFO and interrupt blocks
// ------------------------------------------------------------------
module periph_top
    import periph_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    // AXI4-Lite slave
    input  addr_t      s_awaddr_i,
    input  logic       s_awvalid_i,
    output logic       s_awready_o,
    input  data_t      s_wdata_i,
    input  logic [3:0] s_wstrb_i,
    input  logic       s_wvalid_i,
    output logic       s_wready_o,
    output resp_t      s_bresp_o,
    output logic       s_bvalid_o,
    input  logic       s_bready_i,
    input  addr_t      s_araddr_i,
    input  logic       s_arvalid_i,
    output logic       s_arready_o,
    output data_t      s_rdata_o,
    output resp_t      s_rresp_o,
    output logic       s_rvalid_o,
    input  logic       s_rready_i,
    // Board I/O
    input  led_t       dip_switches_i,
    output led_t       leds_o,
    output logic       irq_o
);

    logic     led_we, irq_en_we, irq_clr_we, rng_pop;
    data_t    wdata;
    led_t     dip_q;
    data_t    rng_data;
    cnt_t     rng_count;
    logic     rng_full, rng_empty;
    irq_vec_t irq_pend, irq_en;
    logic     dip_changed;

    periph_ctrl u_ctrl (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .s_awaddr_i   (s_awaddr_i),
        .s_awvalid_i  (s_awvalid_i),
        .s_awready_o  (s_awready_o),
        .s_wdata_i    (s_wdata_i),
        .s_wstrb_i    (s_wstrb_i),
        .s_wvalid_i   (s_wvalid_i),
        .s_wready_o   (s_wready_o),
        .s_bresp_o    (s_bresp_o),
        .s_bvalid_o   (s_bvalid_o),
        .s_bready_i   (s_bready_i),
        .s_araddr_i   (s_araddr_i),
        .s_arvalid_i  (s_arvalid_i),
        .s_arready_o  (s_arready_o),
        .s_rdata_o    (s_rdata_o),
        .s_rresp_o    (s_rresp_o),
        .s_rvalid_o   (s_rvalid_o),
        .s_rready_i   (s_rready_i),
        .led_we_o     (led_we),
        .irq_en_we_o  (irq_en_we),
        .irq_clr_we_o (irq_clr_we),
        .rng_pop_o    (rng_pop),
        .wdata_o      (wdata),
        .led_q_i      (leds_o),  // LED readback straight from the register
        .dip_q_i      (dip_q),
        .rng_data_i   (rng_data),
        .rng_count_i  (rng_count),
        .rng_full_i   (rng_full),
        .rng_empty_i  (rng_empty),
        .irq_pend_i   (irq_pend),
        .irq_en_i     (irq_en)
    );

    gpio_regs u_gpio (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .led_we_i       (led_we),
        .wdata_i        (wdata),
        .dip_switches_i (dip_switches_i),
        .leds_o         (leds_o),
        .dip_q_o        (dip_q),
        .dip_changed_o  (dip_changed)
    );

    rng_fifo u_rng (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .pop_i   (rng_pop),
        .data_o  (rng_data),
        .count_o (rng_count),
        .full_o  (rng_full),
        .empty_o (rng_empty)
    );

    irq_unit u_irq (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .en_we_i       (irq_en_we),
        .clr_we_i      (irq_clr_we),
        .wdata_i       (wdata),
        .rng_full_i    (rng_full),   // Level source for bit 0
        .dip_changed_i (dip_changed),
        .pend_o        (irq_pend),
        .en_o          (irq_en),
        .irq_o         (irq_o)
    );

endmodule

/* tests/tb_tasks.svh */
// ----------------------------------------------------------------------
// Testbench helpers for the peripheral subsystem
// AXI4-Lite master tasks with timeouts, stimulus LFSR and checks
// ----------------------------------------------------------------------
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// Shift left, XOR of the tapped bits into bit 0
function automatic data_t lfsr_next(input data_t state, input data_t taps);
    return {state[30:0], ^(state & taps)};
endfunction

// One LFSR step per bit taken
function automatic data_t take_bits(input int n);
    data_t v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
        stim_lfsr = lfsr_next(stim_lfsr, STIM_TAPS);
        v = {v[30:0], stim_lfsr[0]};
    end
    return v;
endfunction

function automatic addr_t reg_addr(input reg_idx_t idx);
    return {2'b00, idx, 2'b00};
endfunction

task automatic check_value(input string name, input data_t got, input data_t exp);
    checks++;
    assert (got === exp)
    else
    begin
        errors++;
        $display("mismatch %s: got %h, expected %h", name, got, exp);
    end
endtask

// Stops this process and hands control back to the main sequence
task automatic abort_run(input string why);
    errors++;
    $display("timeout: %s", why);
    -> abort_ev;
    forever @(posedge clk_i);
endtask

// ----------------------------------------------------------------------
// AXI4-Lite master
// ----------------------------------------------------------------------
task automatic axi_write(input reg_idx_t idx, input data_t data, input int stall,
                         output resp_t resp);
    int n;
    s_awaddr_i  <= reg_addr(idx);
    s_wdata_i   <= data;
    s_wstrb_i   <= 4'hf;
    s_awvalid_i <= 1'b1;
    s_wvalid_i  <= 1'b1;
    n = 0;
    @(posedge clk_i);
    while (!(s_awready_o && s_wready_o) && n < HS_TIMEOUT)
    begin
        @(posedge clk_i);
        n++;
    end
    if (!(s_awready_o && s_wready_o))
        abort_run("write address and data were never accepted");
    s_awvalid_i <= 1'b0;
    s_wvalid_i  <= 1'b0;
    n = 0;
    @(posedge clk_i);
    while (!s_bvalid_o && n < HS_TIMEOUT)
    begin
        @(posedge clk_i);
        n++;
    end
    if (!s_bvalid_o)
        abort_run("write response never arrived");
    resp = s_bresp_o;
    repeat (stall)
    begin
        @(posedge clk_i);
        check_value("s_bvalid_o", s_bvalid_o, 1'b1);  // Must hold under back-pressure
        check_value("s_bresp_o", s_bresp_o, resp);
    end
    s_bready_i <= 1'b1;
    @(posedge clk_i);
    check_value("s_bvalid_o", s_bvalid_o, 1'b1);  // Handshake edge
    s_bready_i <= 1'b0;
endtask

task automatic axi_read(input reg_idx_t idx, input int stall, output data_t data,
                        output resp_t resp);
    int n;
    s_araddr_i  <= reg_addr(idx);
    s_arvalid_i <= 1'b1;
    n = 0;
    @(posedge clk_i);
    while (!s_arready_o && n < HS_TIMEOUT)
    begin
        @(posedge clk_i);
        n++;
    end
    if (!s_arready_o)
        abort_run("read address was never accepted");
    s_arvalid_i <= 1'b0;
    n = 0;
    @(posedge clk_i);
    while (!s_rvalid_o && n < HS_TIMEOUT)
    begin
        @(posedge clk_i);
        n++;
    end
    if (!s_rvalid_o)
        abort_run("read data never arrived");
    data = s_rdata_o;
    resp = s_rresp_o;
    repeat (stall)
    begin
        @(posedge clk_i);
        check_value("s_rvalid_o", s_rvalid_o, 1'b1);
        check_value("s_rdata_o", s_rdata_o, data);
        check_value("s_rresp_o", s_rresp_o, resp);
    end
    s_rready_i <= 1'b1;
    @(posedge clk_i);
    check_value("s_rvalid_o", s_rvalid_o, 1'b1);
    s_rready_i <= 1'b0;
endtask

task automatic write_reg(input reg_idx_t idx, input data_t data, input resp_t exp_resp);
    resp_t resp;
    axi_write(idx, data, 0, resp);
    check_value("s_bresp_o", resp, exp_resp);
endtask

task automatic read_check(input reg_idx_t idx, input data_t exp_data, input resp_t exp_resp);
    data_t data;
    resp_t resp;
    axi_read(idx, 0, data, resp);
    check_value("s_rdata_o", data, exp_data);
    check_value("s_rresp_o", resp, exp_resp);
endtask

`endif

/* tests/tb_periph.sv */
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Peripheral subsystem testbench
// Random AXI4-Lite traffic checked against a register model, RNG
// sequence, interrupt and back-pressure tests
// ----------------------------------------------------------------------
module tb_periph
    import periph_pkg::*;
();

    localparam int    HS_TIMEOUT = 50;  // Cycles allowed per handshake
    localparam data_t STIM_SEED  = 32'h5e8b;
    localparam data_t STIM_TAPS  = 32'h8020_0003;

    logic       clk_i = 1'b0;
    logic       rst_i;
    addr_t      s_awaddr_i;
    logic       s_awvalid_i;
    logic       s_awready_o;
    data_t      s_wdata_i;
    logic [3:0] s_wstrb_i;
    logic       s_wvalid_i;
    logic       s_wready_o;
    resp_t      s_bresp_o;
    logic       s_bvalid_o;
    logic       s_bready_i;
    addr_t      s_araddr_i;
    logic       s_arvalid_i;
    logic       s_arready_o;
    data_t      s_rdata_o;
    resp_t      s_rresp_o;
    logic       s_rvalid_o;
    logic       s_rready_i;
    led_t       dip_switches_i;
    led_t       leds_o;
    logic       irq_o;

    int    checks        = 0;
    int    errors        = 0;
    int    test_err_base = 0;
    event  abort_ev;
    data_t stim_lfsr     = STIM_SEED;

    // ----------------------------------------------------------------------
    // Register model
    // ----------------------------------------------------------------------
    led_t     led_model        = '0;
    led_t     dip_model        = '0;
    data_t    rng_model        = RNG_SEED;  // Next word the FIFO should return
    cnt_t     fifo_count_model = '0;
    irq_vec_t pend_model       = '0;
    irq_vec_t en_model         = '0;

    always #2 clk_i = ~clk_i;

    periph_top u_dut (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .s_awaddr_i     (s_awaddr_i),
        .s_awvalid_i    (s_awvalid_i),
        .s_awready_o    (s_awready_o),
        .s_wdata_i      (s_wdata_i),
        .s_wstrb_i      (s_wstrb_i),
        .s_wvalid_i     (s_wvalid_i),
        .s_wready_o     (s_wready_o),
        .s_bresp_o      (s_bresp_o),
        .s_bvalid_o     (s_bvalid_o),
        .s_bready_i     (s_bready_i),
        .s_araddr_i     (s_araddr_i),
        .s_arvalid_i    (s_arvalid_i),
        .s_arready_o    (s_arready_o),
        .s_rdata_o      (s_rdata_o),
        .s_rresp_o      (s_rresp_o),
        .s_rvalid_o     (s_rvalid_o),
        .s_rready_i     (s_rready_i),
        .dip_switches_i (dip_switches_i),
        .leds_o         (leds_o),
        .irq_o          (irq_o)
    );

    `include "tb_tasks.svh"

    task automatic finish_test(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, errors - test_err_base);
        test_err_base = errors;
    endtask

    function automatic data_t stat_word();
        return {fifo_count_model == cnt_t'(RNG_DEPTH), fifo_count_model == 4'd0,
                26'b0, fifo_count_model};
    endfunction

    task automatic led_write_read(input int wstall, input int rstall);
        data_t wd;
        data_t rd;
        resp_t resp;
        wd = take_bits(32);
        axi_write(REG_LEDS, wd, wstall, resp);
        check_value("s_bresp_o", resp, RESP_OKAY);
        led_model = wd[7:0];  // Only the low byte is kept
        check_value("leds_o", leds_o, led_model);
        axi_read(REG_LEDS, rstall, rd, resp);
        check_value("s_rdata_o", rd, led_model);
        check_value("s_rresp_o", resp, RESP_OKAY);
    endtask

    task automatic rng_read_next(input int stall);
        data_t rd;
        resp_t resp;
        axi_read(REG_RNG_DATA, stall, rd, resp);
        check_value("s_rdata_o", rd, rng_model);
        check_value("s_rresp_o", resp, RESP_OKAY);
        rng_model = lfsr_next(rng_model, RNG_TAPS);
    endtask

    // New DIP value that always differs from the old one
    task automatic drive_new_dip();
        led_t v;
        v = led_t'(take_bits(8));
        if (v == dip_model)
            v = ~v;
        dip_model      = v;
        dip_switches_i <= v;
        pend_model[1]  = 1'b1;
    endtask

    task automatic wait_irq(input logic level, input int limit);
        int n;
        n = 0;
        while (irq_o !== level && n < limit)
        begin
            @(posedge clk_i);
            n++;
        end
        checks++;
        assert (irq_o === level)
        else
        begin
            errors++;
            $display("irq_o did not reach %0b within %0d cycles", level, limit);
        end
    endtask

    task automatic run_tests();
        reg_idx_t idx;
        check_value("leds_o", leds_o, 8'h00);  // Reset state
        check_value("irq_o", irq_o, 1'b0);
        check_value("s_awready_o", s_awready_o, 1'b0);
        check_value("s_wready_o", s_wready_o, 1'b0);
        check_value("s_arready_o", s_arready_o, 1'b0);
        check_value("s_bvalid_o", s_bvalid_o, 1'b0);
        check_value("s_rvalid_o", s_rvalid_o, 1'b0);
        repeat (20) led_write_read(0, 0);
        finish_test(1, "led register");

        drive_new_dip();
        repeat (4) @(posedge clk_i);  // Two synchronizer stages plus margin
        read_check(REG_DIP, dip_model, RESP_OKAY);
        finish_test(2, "dip read");

        repeat (12) @(posedge clk_i);
        fifo_count_model = cnt_t'(RNG_DEPTH);
        pend_model[0]    = 1'b1;
        read_check(REG_RNG_STAT, stat_word(), RESP_OKAY);
        repeat (30) rng_read_next(0);
        read_check(REG_RNG_STAT, stat_word(), RESP_OKAY);
        finish_test(3, "rng fifo");

        // Interrupts with all enables still clear
        drive_new_dip();
        repeat (8)
        begin
            @(posedge clk_i);
            check_value("irq_o", irq_o, 1'b0);
        end
        read_check(REG_IRQ_PEND, pend_model, RESP_OKAY);
        write_reg(REG_IRQ_PEND, 32'h2, RESP_OKAY);
        pend_model[1] = 1'b0;
        read_check(REG_IRQ_PEND, pend_model, RESP_OKAY);
        write_reg(REG_IRQ_EN, 32'h2, RESP_OKAY);
        en_model = 2'b10;
        check_value("irq_o", irq_o, 1'b0);
        drive_new_dip();
        repeat (2) @(posedge clk_i);
        wait_irq(1'b1, 5);
        read_check(REG_IRQ_PEND, pend_model, RESP_OKAY);
        write_reg(REG_IRQ_PEND, 32'h2, RESP_OKAY);
        pend_model[1] = 1'b0;
        wait_irq(1'b0, 3);
        write_reg(REG_IRQ_EN, 32'h1, RESP_OKAY);  // FIFO full source
        en_model = 2'b01;
        wait_irq(1'b1, 3);
        read_check(REG_IRQ_EN, en_model, RESP_OKAY);
        write_reg(REG_IRQ_EN, 32'h0, RESP_OKAY);
        en_model = 2'b00;
        finish_test(4, "interrupts");

        repeat (5)
        begin
            idx = reg_idx_t'(6 + take_bits(4) % 10);
            read_check(idx, BAD_DATA, RESP_SLVERR);
            write_reg(idx, take_bits(32), RESP_SLVERR);
        end
        write_reg(REG_DIP, take_bits(32), RESP_OKAY);  // Read-only register ignores it
        read_check(REG_LEDS, led_model, RESP_OKAY);
        read_check(REG_DIP, dip_model, RESP_OKAY);
        read_check(REG_IRQ_EN, en_model, RESP_OKAY);
        check_value("leds_o", leds_o, led_model);
        finish_test(5, "unmapped access");

        repeat (12)
        begin
            led_write_read(take_bits(3), take_bits(3));
            rng_read_next(take_bits(3));
        end
        finish_test(6, "back-pressure");
    endtask

    initial
    begin
        rst_i          = 1'b1;
        s_awaddr_i     = '0;
        s_awvalid_i    = 1'b0;
        s_wdata_i      = '0;
        s_wstrb_i      = 4'h0;
        s_wvalid_i     = 1'b0;
        s_bready_i     = 1'b0;
        s_araddr_i     = '0;
        s_arvalid_i    = 1'b0;
        s_rready_i     = 1'b0;
        dip_switches_i = '0;
        repeat (16) @(posedge clk_i);
        rst_i <= 1'b0;
        fork
            run_tests();
            @(abort_ev);
        join_any
        disable fork;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+tests
hw/periph_pkg.sv
hw/gpio_regs.sv
hw/rng_fifo.sv
hw/irq_unit.sv
hw/periph_ctrl.sv
hw/periph_top.sv
tests/tb_periph.sv
